// ==== project.f ====
+incdir+src
src/cacheTypesPkg.sv
src/memBusPkg.sv
src/tagStore.sv
src/dataStore.sv
src/missRefill.sv
src/cacheCtrl.sv
src/iCacheTop.sv
tests/memSlaveModel.sv
tests/iCacheTb.sv

// ==== Makefile ====
# Verilator build and run of the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= iCacheTb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/10ps -Wno-fatal
PASS_MSG  ?= TEST RESULT: PASS

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh tests/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# status comes from the search for the pass line
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/iCacheTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "iCache_cfg.svh"

module iCacheTb;
  import cacheTypesPkg::*;
  import memBusPkg::*;

  localparam int CLK_PERIOD    = 8;
  localparam int RESET_CYCLES  = 4;
  localparam int DIRECTED_REQS = 26;
  localparam int STREAM_REQS   = 300;
  // worst case cycles per request for pipeline, memory delay, refill and replay
  localparam int WATCHDOG_NS   = (DIRECTED_REQS + STREAM_REQS) * (4 + 7 + 12) * CLK_PERIOD
                                 + RESET_CYCLES * CLK_PERIOD;

  logic     clk;
  logic     rst_n;
  logic     reqValid;
  cacheReqT reqData;
  logic     reqCredit;
  logic     rspValid;
  cacheRspT rspData;
  logic     memReqValid;
  memReqT   memReq;
  logic     memReqReady;
  logic     memBeatValid;
  memBeatT  memBeat;

  addrT   expQ [$];
  int     credits;
  int     refills;
  int     responses;
  int     checks;
  int     errors;
  integer seed;
  string  testName;

  iCacheTop uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (reqValid),
    .reqData_i      (reqData),
    .reqCredit_o    (reqCredit),
    .rspValid_o     (rspValid),
    .rspData_o      (rspData),
    .memReqValid_o  (memReqValid),
    .memReq_o       (memReq),
    .memReqReady_i  (memReqReady),
    .memBeatValid_i (memBeatValid),
    .memBeat_i      (memBeat)
  );

  memSlaveModel uMem (
    .clk            (clk),
    .rst_n          (rst_n),
    .memReqValid_i  (memReqValid),
    .memReq_i       (memReq),
    .memReqReady_o  (memReqReady),
    .memBeatValid_o (memBeatValid),
    .memBeat_o      (memBeat)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // expected memory word for a byte address
  function automatic wordT memWord(input logic [31:0] addr);
    logic [31:0] a;
    a = {addr[31:3], 3'b000};
    return {a ^ 32'hC3A5_5A3C, a};
  endfunction

  function automatic addrT mkAddr(input int tag, input int idx, input int wsel);
    addrT a;
    a.tag     = tagT'(tag);
    a.index   = indexT'(idx);
    a.wordSel = wordSelT'(wsel);
    a.byteOff = '0;
    return a;
  endfunction

  task automatic checkRsp(input string name, input cacheRspT exp, input cacheRspT act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected addr %h data %h, actual addr %h data %h",
               name, exp.addr, exp.data, act.addr, act.data);
    end
  endtask

  task automatic checkMemReq(input string name, input memReqT exp, input memReqT act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("MISMATCH %s: expected line tag %h index %h, actual line tag %h index %h",
               name, exp.tag, exp.index, act.tag, act.index);
    end
  endtask

  task automatic checkCount(input string name, input int exp, input int act);
    checks++;
    if (exp != act) begin
      errors++;
      $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  // core side, called and returning 1 ns after a rising edge
  task automatic sendReq(input addrT addr);
    while (credits == 0) begin
      @(posedge clk);
      #1;
    end
    if (expQ.size() >= `ICACHE_REQ_CREDITS) begin
      errors++;
      $display("core has %0d requests outstanding, more than its credits", expQ.size());
    end
    reqValid     = 1'b1;
    reqData.addr = addr;
    credits--;
    expQ.push_back(addr);
    @(posedge clk);
    #1;
    reqValid = 1'b0;
  endtask

  task automatic readLine(input int tag, input int idx);
    for (int w = 0; w < `ICACHE_LINE_BEATS; w++) begin
      sendReq(mkAddr(tag, idx, w));
    end
  endtask

  task automatic waitDrain();
    while (expQ.size() != 0) begin
      @(posedge clk);
      #1;
    end
  endtask

  // responses and credits sampled mid-cycle
  always @(negedge clk) begin : rspCompare
    cacheRspT expRsp;
    if (rst_n === 1'b1 && rspValid === 1'b1) begin
      responses++;
      if (expQ.size() == 0) begin
        errors++;
        $display("response for address %h came with no request outstanding", rspData.addr);
      end else begin
        expRsp.addr = expQ.pop_front();
        expRsp.data = memWord(expRsp.addr);
        checkRsp(testName, expRsp, rspData);
      end
    end
    if (rst_n === 1'b1 && reqCredit === 1'b1) begin
      credits++;
      if (credits > `ICACHE_REQ_CREDITS) begin
        errors++;
        $display("cache returned a credit that the core never spent");
      end
    end
  end

  // one count per memory request handshake
  always @(negedge clk) begin : memReqCount
    memReqT expReq;
    addrT   head;
    if (rst_n === 1'b1 && memReqValid === 1'b1 && memReqReady === 1'b1) begin
      refills++;
      if (expQ.size() == 0) begin
        errors++;
        $display("memory request for line %h made with no request outstanding", memReq);
      end else begin
        // the stalled miss is the oldest outstanding request
        head         = expQ[0];
        expReq.tag   = head.tag;
        expReq.index = head.index;
        checkMemReq(testName, expReq, memReq);
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with %0d responses, the cache stopped answering",
             WATCHDOG_NS, responses);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int r;
    int base;
    clk       = 1'b0;
    rst_n     = 1'b0;
    reqValid  = 1'b0;
    reqData   = '0;
    credits   = `ICACHE_REQ_CREDITS;
    refills   = 0;
    responses = 0;
    checks    = 0;
    errors    = 0;
    seed      = 13;
    testName  = "reset";
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    checks++;
    if (rspValid !== 1'b0 || reqCredit !== 1'b0 || memReqValid !== 1'b0) begin
      errors++;
      $display("outputs not idle after reset: rsp %b credit %b memReq %b",
               rspValid, reqCredit, memReqValid);
    end
    @(posedge clk);
    #1;

    testName = "cold reads";
    base     = refills;
    sendReq(mkAddr(1, 3, 0));
    sendReq(mkAddr(1, 3, 2));
    sendReq(mkAddr(2, 5, 1));
    waitDrain();
    checkCount("cold reads refills", base + 2, refills);

    testName = "line hits";
    base     = refills;
    readLine(1, 3);
    readLine(2, 5);
    waitDrain();
    checkCount("line hits refills", base, refills);

    // two tags in set 9 fill both ways
    testName = "same set";
    base     = refills;
    sendReq(mkAddr(7, 9, 0));
    sendReq(mkAddr(8, 9, 0));
    waitDrain();
    checkCount("same set refills", base + 2, refills);
    readLine(7, 9);
    readLine(8, 9);
    waitDrain();
    checkCount("same set re-read refills", base + 2, refills);

    testName = "third line";
    base     = refills;
    sendReq(mkAddr(9, 9, 1));
    waitDrain();
    checkCount("third line refills", base + 1, refills);
    readLine(9, 9);
    waitDrain();
    checkCount("third line re-read refills", base + 1, refills);

    // four tags over four sets keep both ways busy
    testName = "random stream";
    for (int i = 0; i < STREAM_REQS; i++) begin
      r = $random(seed);
      sendReq(mkAddr(20 + (r & 3), 40 + ((r >> 2) & 3), (r >> 4) & 3));
    end
    waitDrain();
    checkCount("credits returned", `ICACHE_REQ_CREDITS, credits);
    checkCount("total responses", DIRECTED_REQS + STREAM_REQS, responses);

    $display("responses %0d, refills %0d, checks %0d, errors %0d",
             responses, refills, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/memSlaveModel.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "iCache_cfg.svh"

module memSlaveModel (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               memReqValid_i,
  input  memBusPkg::memReqT  memReq_i,
  output logic               memReqReady_o,
  output logic               memBeatValid_o,
  output memBusPkg::memBeatT memBeat_o
);
  import cacheTypesPkg::*;
  import memBusPkg::*;

  integer seed;

  // memory contents follow from the word address alone
  function automatic wordT memWord(input logic [31:0] addr);
    logic [31:0] a;
    a = {addr[31:3], 3'b000};
    return {a ^ 32'hC3A5_5A3C, a};
  endfunction

  // everything is driven 1 ns after the rising edge
  initial begin
    memReqT lineReq;
    int     idle;
    seed           = 13;
    memReqReady_o  = 1'b0;
    memBeatValid_o = 1'b0;
    memBeat_o      = '0;
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      #1;
      // ready drops on about one cycle in four
      memReqReady_o = ($random(seed) & 3) != 0;
      if (memReqValid_i === 1'b1 && memReqReady_o) begin
        lineReq = memReq_i;
        @(posedge clk);
        #1;
        memReqReady_o = 1'b0;
        idle = $random(seed) & 7;
        repeat (idle) begin
          @(posedge clk);
          #1;
        end
        for (int b = 0; b < `ICACHE_LINE_BEATS; b++) begin
          memBeatValid_o = 1'b1;
          memBeat_o.data = memWord({lineReq.tag, lineReq.index, wordSelT'(b), {BYTE_W{1'b0}}});
          memBeat_o.last = (b == `ICACHE_LINE_BEATS - 1);
          @(posedge clk);
          #1;
        end
        memBeatValid_o = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/iCacheTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module iCacheTop (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    reqValid_i,
  input  cacheTypesPkg::cacheReqT reqData_i,
  output logic                    reqCredit_o,
  output logic                    rspValid_o,
  output cacheTypesPkg::cacheRspT rspData_o,
  output logic                    memReqValid_o,
  output memBusPkg::memReqT       memReq_o,
  input  logic                    memReqReady_i,
  input  logic                    memBeatValid_i,
  input  memBusPkg::memBeatT      memBeat_i
);
  import cacheTypesPkg::*;
  import memBusPkg::*;

  logic     rdEn;
  indexT    rdIndex;
  tagRdT    tagRd;
  linePairT lineRd;
  logic     missStart;
  memReqT   missReq;
  logic     refillDone;
  logic     tagWrEn;
  tagT      tagWrTag;
  logic     dataWrEn;
  wordSelT  dataWrBeat;
  wordT     dataWrData;
  logic     wrWay;
  indexT    wrIndex;

  cacheCtrl uCtrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .reqValid_i   (reqValid_i),
    .reqData_i    (reqData_i),
    .reqCredit_o  (reqCredit_o),
    .rspValid_o   (rspValid_o),
    .rspData_o    (rspData_o),
    .rdEn_o       (rdEn),
    .rdIndex_o    (rdIndex),
    .tagRd_i      (tagRd),
    .lineRd_i     (lineRd),
    .missStart_o  (missStart),
    .missReq_o    (missReq),
    .refillDone_i (refillDone)
  );

  tagStore uTagStore (
    .clk       (clk),
    .rst_n     (rst_n),
    .rdEn_i    (rdEn),
    .rdIndex_i (rdIndex),
    .tagRd_o   (tagRd),
    .wrEn_i    (tagWrEn),
    .wrWay_i   (wrWay),
    .wrIndex_i (wrIndex),
    .wrTag_i   (tagWrTag)
  );

  dataStore uDataStore (
    .clk       (clk),
    .rdEn_i    (rdEn),
    .rdIndex_i (rdIndex),
    .lineRd_o  (lineRd),
    .wrEn_i    (dataWrEn),
    .wrWay_i   (wrWay),
    .wrIndex_i (wrIndex),
    .wrBeat_i  (dataWrBeat),
    .wrData_i  (dataWrData)
  );

  // victim choice uses the valid bits the compare stage just looked at
  missRefill uRefill (
    .clk            (clk),
    .rst_n          (rst_n),
    .missStart_i    (missStart),
    .missReq_i      (missReq),
    .wayValid_i     (tagRd.valid),
    .memReqValid_o  (memReqValid_o),
    .memReq_o       (memReq_o),
    .memReqReady_i  (memReqReady_i),
    .memBeatValid_i (memBeatValid_i),
    .memBeat_i      (memBeat_i),
    .tagWrEn_o      (tagWrEn),
    .tagWrTag_o     (tagWrTag),
    .dataWrEn_o     (dataWrEn),
    .dataWrBeat_o   (dataWrBeat),
    .dataWrData_o   (dataWrData),
    .wrWay_o        (wrWay),
    .wrIndex_o      (wrIndex),
    .refillDone_o   (refillDone)
  );

endmodule

`default_nettype wire

// ==== src/cacheCtrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "iCache_cfg.svh"

module cacheCtrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    reqValid_i,
  input  cacheTypesPkg::cacheReqT reqData_i,
  output logic                    reqCredit_o,
  output logic                    rspValid_o,
  output cacheTypesPkg::cacheRspT rspData_o,
  output logic                    rdEn_o,
  output cacheTypesPkg::indexT    rdIndex_o,
  input  cacheTypesPkg::tagRdT    tagRd_i,
  input  cacheTypesPkg::linePairT lineRd_i,
  output logic                    missStart_o,
  output memBusPkg::memReqT       missReq_o,
  input  logic                    refillDone_i
);
  import cacheTypesPkg::*;

  localparam int QDEPTH = `ICACHE_REQ_CREDITS;
  localparam int PTR_W  = (QDEPTH > 1) ? $clog2(QDEPTH) : 1;
  localparam int CNT_W  = $clog2(QDEPTH + 1);

  ctrlStateE        state;
  ctrlStateE        stateNext;
  cacheReqT         qMem [QDEPTH];
  logic [PTR_W-1:0] qWrPtr;
  logic [PTR_W-1:0] qRdPtr;
  logic [CNT_W-1:0] qCount;
  logic             qFull;
  logic             qEmpty;
  logic             qPop;
  logic             lkValid;
  cacheReqT         lkReq;
  logic             cmpValid;
  cacheReqT         cmpReq;
  lookupT           cmpStage;
  logic [1:0]       wayHit;
  logic             cmpHit;
  logic             cmpMiss;
  logic             advance;
  logic             rspFire;
  wordT             hitWord;

  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(QDEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // request queue sized by the credit count so it cannot overflow
  assign qFull  = (qCount == CNT_W'(QDEPTH));
  assign qEmpty = (qCount == '0);
  assign qPop   = !qEmpty && (!lkValid || advance);

  always_ff @(posedge clk) begin
    if (reqValid_i) begin
      qMem[qWrPtr] <= reqData_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      qWrPtr <= '0;
      qRdPtr <= '0;
      qCount <= '0;
    end else begin
      if (reqValid_i) qWrPtr <= nextPtr(qWrPtr);
      if (qPop) qRdPtr <= nextPtr(qRdPtr);
      qCount <= qCount + CNT_W'(reqValid_i) - CNT_W'(qPop);
    end
  end

  // compare stage sees the store outputs read during its lookup cycle
  always_comb begin
    cmpStage.valid    = cmpValid;
    cmpStage.req      = cmpReq;
    cmpStage.tag      = tagRd_i.tag;
    cmpStage.wayValid = tagRd_i.valid;
    for (int w = 0; w < 2; w++) begin
      wayHit[w] = cmpStage.wayValid[w] && (cmpStage.tag[w] == cmpStage.req.addr.tag);
    end
  end

  assign cmpHit  = cmpStage.valid && (|wayHit);
  assign cmpMiss = (state == RUN) && cmpStage.valid && !(|wayHit);
  assign hitWord = lineRd_i[wayHit[1]][cmpStage.req.addr.wordSel];
  assign rspFire = (state == RUN) && cmpHit;

  // pipeline moves only in RUN with no miss sitting in compare
  assign advance = (state == RUN) && !cmpMiss;

  always_comb begin
    stateNext = state;
    case (state)
      RUN:     if (cmpMiss) stateNext = REFILL;
      REFILL:  if (refillDone_i) stateNext = REPLAY;
      REPLAY:  stateNext = RUN;
      default: stateNext = RUN;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= RUN;
      lkValid  <= 1'b0;
      cmpValid <= 1'b0;
    end else begin
      state <= stateNext;
      if (advance || !lkValid) lkValid <= qPop;
      if (advance) cmpValid <= lkValid;
    end
  end

  always_ff @(posedge clk) begin
    if (qPop) lkReq <= qMem[qRdPtr];
    if (advance) cmpReq <= lkReq;
  end

  // replay re-reads the stalled compare item and the item behind reads as it advances
  assign rdEn_o    = (state == REPLAY) || (advance && lkValid);
  assign rdIndex_o = (state == REPLAY) ? cmpReq.addr.index : lkReq.addr.index;

  assign missStart_o = cmpMiss;
  always_comb begin
    missReq_o.tag   = cmpReq.addr.tag;
    missReq_o.index = cmpReq.addr.index;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rspValid_o <= 1'b0;
    end else begin
      rspValid_o <= rspFire;
    end
  end

  always_ff @(posedge clk) begin
    if (rspFire) begin
      rspData_o.data <= hitWord;
      rspData_o.addr <= cmpStage.req.addr;
    end
  end

  // each response hands one credit back
  assign reqCredit_o = rspValid_o;

  // a core that respects its credits never pushes into a full queue
  noPushWhenFull: assert property (
    @(posedge clk) disable iff (!rst_n) reqValid_i |-> !qFull
  ) else $error("cacheCtrl: request arrived with the queue full");

endmodule

`default_nettype wire

// ==== src/missRefill.sv ====
`timescale 1ns/10ps
`default_nettype none

module missRefill (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   missStart_i,
  input  memBusPkg::memReqT      missReq_i,
  input  logic [1:0]             wayValid_i,
  output logic                   memReqValid_o,
  output memBusPkg::memReqT      memReq_o,
  input  logic                   memReqReady_i,
  input  logic                   memBeatValid_i,
  input  memBusPkg::memBeatT     memBeat_i,
  output logic                   tagWrEn_o,
  output cacheTypesPkg::tagT     tagWrTag_o,
  output logic                   dataWrEn_o,
  output cacheTypesPkg::wordSelT dataWrBeat_o,
  output cacheTypesPkg::wordT    dataWrData_o,
  output logic                   wrWay_o,
  output cacheTypesPkg::indexT   wrIndex_o,
  output logic                   refillDone_o
);
  import cacheTypesPkg::*;
  import memBusPkg::*;

  refillStateE state;
  refillStateE stateNext;
  memReqT      lineReq;
  logic        victimWay;
  logic        pickWay;
  wordSelT     beatCnt;
  logic [7:0]  lfsr;

  // empty way first or else the lfsr bit
  always_comb begin
    if (!wayValid_i[0]) begin
      pickWay = 1'b0;
    end else if (!wayValid_i[1]) begin
      pickWay = 1'b1;
    end else begin
      pickWay = lfsr[0];
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      R_IDLE:  if (missStart_i) stateNext = R_REQ;
      R_REQ:   if (memReqReady_i) stateNext = R_BEATS;
      R_BEATS: if (memBeatValid_i && memBeat_i.last) stateNext = R_DONE;
      R_DONE:  stateNext = R_IDLE;
      default: stateNext = R_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= R_IDLE;
      victimWay <= 1'b0;
      beatCnt   <= '0;
      lfsr      <= 8'h01;
    end else begin
      state <= stateNext;
      if (state == R_IDLE && missStart_i) begin
        victimWay <= pickWay;
        // x^8 + x^6 + x^5 + x^4 + 1 stepped once per refill
        lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
      end
      if (state == R_REQ) begin
        beatCnt <= '0;
      end else if (dataWrEn_o) begin
        beatCnt <= beatCnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == R_IDLE && missStart_i) begin
      lineReq <= missReq_i;
    end
  end

  assign memReqValid_o = (state == R_REQ);
  assign memReq_o      = lineReq;

  // beats land in order and the tag goes in last so the line turns valid complete
  assign dataWrEn_o   = (state == R_BEATS) && memBeatValid_i;
  assign dataWrBeat_o = beatCnt;
  assign dataWrData_o = memBeat_i.data;
  assign tagWrEn_o    = (state == R_DONE);
  assign tagWrTag_o   = lineReq.tag;
  assign wrWay_o      = victimWay;
  assign wrIndex_o    = lineReq.index;
  assign refillDone_o = (state == R_DONE);

  // memory must not stream beats before the request handshake or after last
  beatOnlyInBeats: assert property (
    @(posedge clk) disable iff (!rst_n) memBeatValid_i |-> (state == R_BEATS)
  ) else $error("missRefill: beat outside of a refill burst");

endmodule

`default_nettype wire

// ==== src/dataStore.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "iCache_cfg.svh"

module dataStore (
  input  logic                    clk,
  input  logic                    rdEn_i,
  input  cacheTypesPkg::indexT    rdIndex_i,
  output cacheTypesPkg::linePairT lineRd_o,
  input  logic                    wrEn_i,
  input  logic                    wrWay_i,
  input  cacheTypesPkg::indexT    wrIndex_i,
  input  cacheTypesPkg::wordSelT  wrBeat_i,
  input  cacheTypesPkg::wordT     wrData_i
);
  import cacheTypesPkg::*;

  lineT dataArr [2][`ICACHE_SETS];

  // one word per refill beat
  always_ff @(posedge clk) begin
    if (wrEn_i) begin
      dataArr[wrWay_i][wrIndex_i][wrBeat_i] <= wrData_i;
    end
  end

  // whole line of both ways for the word pick in the compare stage
  always_ff @(posedge clk) begin
    if (rdEn_i) begin
      for (int w = 0; w < 2; w++) begin
        lineRd_o[w] <= dataArr[w][rdIndex_i];
      end
    end
  end

  // refill writes and lookup reads are kept apart by the controller stall
  noRdWrSameSet: assert property (
    @(posedge clk) !(rdEn_i && wrEn_i && (rdIndex_i == wrIndex_i))
  ) else $error("dataStore: read and refill write hit set %0d together", rdIndex_i);

endmodule

`default_nettype wire

// ==== src/tagStore.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "iCache_cfg.svh"

module tagStore (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  rdEn_i,
  input  cacheTypesPkg::indexT  rdIndex_i,
  output cacheTypesPkg::tagRdT  tagRd_o,
  input  logic                  wrEn_i,
  input  logic                  wrWay_i,
  input  cacheTypesPkg::indexT  wrIndex_i,
  input  cacheTypesPkg::tagT    wrTag_i
);
  import cacheTypesPkg::*;

  tagT                          tagArr [2][`ICACHE_SETS];
  logic [1:0][`ICACHE_SETS-1:0] validArr;

  logic [1:0] rdValidQ;
  tagT [1:0]  rdTagQ;

  // a fill marks its way valid until the next reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
    end else if (wrEn_i) begin
      validArr[wrWay_i][wrIndex_i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wrEn_i) begin
      tagArr[wrWay_i][wrIndex_i] <= wrTag_i;
    end
  end

  // registered read of both ways
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdValidQ <= '0;
    end else if (rdEn_i) begin
      for (int w = 0; w < 2; w++) begin
        rdValidQ[w] <= validArr[w][rdIndex_i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rdEn_i) begin
      for (int w = 0; w < 2; w++) begin
        rdTagQ[w] <= tagArr[w][rdIndex_i];
      end
    end
  end

  always_comb begin
    tagRd_o.valid = rdValidQ;
    tagRd_o.tag   = rdTagQ;
  end

endmodule

`default_nettype wire

// ==== src/memBusPkg.sv ====
`default_nettype none

package memBusPkg;

  // line address with the word and byte bits implied zero
  typedef struct packed {
    cacheTypesPkg::tagT   tag;
    cacheTypesPkg::indexT index;
  } memReqT;

  typedef struct packed {
    cacheTypesPkg::wordT data;
    logic                last;
  } memBeatT;

  typedef enum logic [1:0] {
    R_IDLE,
    R_REQ,
    R_BEATS,
    R_DONE
  } refillStateE;

endpackage

`default_nettype wire

// ==== src/cacheTypesPkg.sv ====
`default_nettype none

`include "iCache_cfg.svh"

package cacheTypesPkg;

  // address split from the top into tag, index, word select and byte offset
  localparam int OFFSET_W = $clog2(`ICACHE_LINE_BEATS * `ICACHE_XLEN / 8);
  localparam int INDEX_W  = $clog2(`ICACHE_SETS);
  localparam int TAG_W    = `ICACHE_ADDR_W - INDEX_W - OFFSET_W;
  localparam int WSEL_W   = $clog2(`ICACHE_LINE_BEATS);
  localparam int BYTE_W   = OFFSET_W - WSEL_W;

  typedef logic [TAG_W-1:0]        tagT;
  typedef logic [INDEX_W-1:0]      indexT;
  typedef logic [WSEL_W-1:0]       wordSelT;
  typedef logic [`ICACHE_XLEN-1:0] wordT;

  typedef wordT [`ICACHE_LINE_BEATS-1:0] lineT;
  // way 1 in the upper slot
  typedef lineT [1:0] linePairT;

  typedef struct packed {
    tagT               tag;
    indexT             index;
    wordSelT           wordSel;
    logic [BYTE_W-1:0] byteOff;
  } addrT;

  typedef struct packed {
    addrT addr;
  } cacheReqT;

  typedef struct packed {
    wordT data;
    addrT addr;
  } cacheRspT;

  // registered tag store output for both ways
  typedef struct packed {
    logic [1:0] valid;
    tagT [1:0]  tag;
  } tagRdT;

  typedef struct packed {
    logic       valid;
    cacheReqT   req;
    tagT [1:0]  tag;
    logic [1:0] wayValid;
  } lookupT;

  typedef enum logic [1:0] {
    RUN,
    REFILL,
    REPLAY
  } ctrlStateE;

endpackage

`default_nettype wire

// ==== src/iCache_cfg.svh ====
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// byte address width seen by the core
`define ICACHE_ADDR_W 32

// one fetch word
`define ICACHE_XLEN 64

// sets per way
`define ICACHE_SETS 64

// words per line at one per memory beat
`define ICACHE_LINE_BEATS 4

// credits the core holds after reset and the request queue depth
`define ICACHE_REQ_CREDITS 2

`endif
